// ==== design/control_memory.sv ====
`timescale 1ns/10ps

module control_memory (
	input rv32i_types::rv32i_word instr,
	output rv32i_types::rv32i_control_word ctrl
);
	import rv32i_types::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	rv32i_word i_imm;
	rv32i_word s_imm;
	rv32i_word b_imm;
	rv32i_word u_imm;
	rv32i_word j_imm;

	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign i_imm = {{21{instr[31]}}, instr[30:20]};
	assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign u_imm = {instr[31:12], 12'h000};
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		ctrl = nop_ctrl;
		case (instr[6:0])
			op_lui: begin
				ctrl.opcode = op_lui;
				ctrl.rd = instr[11:7];
				ctrl.imm = u_imm;
				ctrl.aluop = alu_pass_b;
				ctrl.alumux2_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
			end
			op_jal: begin
				ctrl.opcode = op_jal;
				ctrl.rd = instr[11:7];
				ctrl.imm = j_imm;
				ctrl.is_jump = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = pc_plus4;
			end
			op_br: if (funct3[2:1] == 2'b00) begin // beq and bne only.
				ctrl.opcode = op_br;
				ctrl.rs1 = instr[19:15];
				ctrl.rs2 = instr[24:20];
				ctrl.imm = b_imm;
				ctrl.is_branch = 1'b1;
				ctrl.branch_ne = funct3[0];
			end
			op_load: if (funct3 == 3'b010) begin
				ctrl.opcode = op_load;
				ctrl.rs1 = instr[19:15];
				ctrl.rd = instr[11:7];
				ctrl.imm = i_imm;
				ctrl.alumux2_sel = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.regfilemux_sel = mem_rdata;
			end
			op_store: if (funct3 == 3'b010) begin
				ctrl.opcode = op_store;
				ctrl.rs1 = instr[19:15];
				ctrl.rs2 = instr[24:20];
				ctrl.imm = s_imm;
				ctrl.alumux2_sel = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			op_imm: if (funct3 == 3'b000) begin // addi.
				ctrl.opcode = op_imm;
				ctrl.rs1 = instr[19:15];
				ctrl.rd = instr[11:7];
				ctrl.imm = i_imm;
				ctrl.alumux2_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
			end
			op_reg: begin
				ctrl.opcode = op_reg;
				ctrl.rs1 = instr[19:15];
				ctrl.rs2 = instr[24:20];
				ctrl.rd = instr[11:7];
				ctrl.load_regfile = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: ctrl.aluop = alu_add;
					10'b0100000_000: ctrl.aluop = alu_sub;
					10'b0000000_100: ctrl.aluop = alu_xor;
					10'b0000000_110: ctrl.aluop = alu_or;
					10'b0000000_111: ctrl.aluop = alu_and;
					default: ctrl = nop_ctrl;
				endcase
			end
			default: ctrl = nop_ctrl;
		endcase
		if (ctrl.rd == '0)
			ctrl.load_regfile = 1'b0; // x0 never written.
	end

endmodule : control_memory

// ==== design/ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage (
	input logic clk,
	input logic rst,
	input rv32i_types::id_ex_t id_ex,
	input logic ex_mem_load,
	input rv32i_types::fwd_sel_t fwd_sel1,
	input rv32i_types::fwd_sel_t fwd_sel2,
	input rv32i_types::rv32i_word mem_fwd_data,
	input rv32i_types::rv32i_word wb_data,
	output rv32i_types::ex_mem_t ex_mem,
	output logic br_taken,
	output rv32i_types::rv32i_word br_target
);
	import rv32i_types::*;

	rv32i_control_word ex_ctrl;
	rv32i_word opa;
	rv32i_word rs2_fwd;
	rv32i_word opb;
	rv32i_word alu_res;
	logic eq;

	function automatic rv32i_word fwd_mux(fwd_sel_t sel, rv32i_word reg_val,
			rv32i_word mem_val, rv32i_word wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign ex_ctrl = id_ex.ctrl;

	always_comb begin
		opa = fwd_mux(fwd_sel1, id_ex.rs1_val, mem_fwd_data, wb_data);
		rs2_fwd = fwd_mux(fwd_sel2, id_ex.rs2_val, mem_fwd_data, wb_data);
	end

	assign opb = ex_ctrl.alumux2_sel ? ex_ctrl.imm : rs2_fwd;

	always_comb begin
		case (ex_ctrl.aluop)
			alu_sub: alu_res = opa - opb;
			alu_and: alu_res = opa & opb;
			alu_or: alu_res = opa | opb;
			alu_xor: alu_res = opa ^ opb;
			alu_pass_b: alu_res = opb; // lui.
			default: alu_res = opa + opb;
		endcase
	end

	assign eq = (opa == rs2_fwd);
	// bne wants the compare false.
	assign br_taken = ex_ctrl.is_jump | (ex_ctrl.is_branch & (eq ^ ex_ctrl.branch_ne));
	assign br_target = id_ex.pc + ex_ctrl.imm;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem <= '{pc: '0, alu_out: '0, store_data: '0, ctrl: nop_ctrl};
		end else if (ex_mem_load) begin
			ex_mem <= '{
				pc: id_ex.pc,
				alu_out: alu_res,
				store_data: rs2_fwd,
				ctrl: ex_ctrl
			};
		end
	end

endmodule : ex_stage

// ==== design/id_stage.sv ====
`timescale 1ns/10ps

module id_stage (
	input logic clk,
	input logic rst,
	input rv32i_types::if_id_t if_id,
	input rv32i_types::rv32i_control_word ctrl,
	input logic id_ex_load,
	input logic id_ex_flush,
	input rv32i_types::rv32i_reg wb_rd,
	input logic wb_we,
	input rv32i_types::rv32i_word wb_data,
	output rv32i_types::id_ex_t id_ex
);
	import rv32i_types::*;

	rv32i_word regs [32];
	rv32i_word rs1_val;
	rv32i_word rs2_val;

	// same-cycle WB write is visible to the read.
	function automatic rv32i_word read_port(rv32i_reg idx, rv32i_reg w_idx, logic we,
			rv32i_word w_data, rv32i_word r_data);
		if (idx == '0)
			return '0;
		if (we && w_idx == idx)
			return w_data;
		return r_data;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_we && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	always_comb begin
		rs1_val = read_port(ctrl.rs1, wb_rd, wb_we, wb_data, regs[ctrl.rs1]);
		rs2_val = read_port(ctrl.rs2, wb_rd, wb_we, wb_data, regs[ctrl.rs2]);
	end

	always_ff @(posedge clk) begin
		if (rst || id_ex_flush) begin
			id_ex <= '{pc: '0, rs1_val: '0, rs2_val: '0, ctrl: nop_ctrl};
		end else if (id_ex_load) begin
			id_ex <= '{pc: if_id.pc, rs1_val: rs1_val, rs2_val: rs2_val, ctrl: ctrl};
		end
	end

	// decoder drops load_regfile for rd 0, so WB never targets x0.
	assert property (@(posedge clk) disable iff (rst) wb_we |-> wb_rd != '0);

endmodule : id_stage

// ==== design/if_stage.sv ====
`timescale 1ns/10ps

module if_stage (
	input logic clk,
	input logic rst,
	input logic pc_load,
	input logic if_id_load,
	input logic if_id_flush,
	input logic br_taken,
	input rv32i_types::rv32i_word br_target,
	input rv32i_types::rv32i_word rdata_a,
	output rv32i_types::rv32i_word address_a,
	output rv32i_types::if_id_t if_id
);
	import rv32i_types::*;

	rv32i_word pc;
	rv32i_word pc_next;

	assign pc_next = br_taken ? br_target : pc + 32'd4;
	assign address_a = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (pc_load) begin
			pc <= pc_next;
		end
	end

	// all-zero instr decodes as a bubble.
	always_ff @(posedge clk) begin
		if (rst || if_id_flush) begin
			if_id <= '{pc: '0, instr: '0};
		end else if (if_id_load) begin
			if_id <= '{pc: pc, instr: rdata_a};
		end
	end

endmodule : if_stage

// ==== design/mp3_cpu.sv ====
`timescale 1ns/10ps

module mp3_cpu (
	input logic clk,
	input logic rst,

	// instruction port
	output logic read_a,
	output logic write_a,
	output logic [3:0] wmask_a,
	output rv32i_types::rv32i_word address_a,
	output rv32i_types::rv32i_word wdata_a,
	input logic resp_a,
	input rv32i_types::rv32i_word rdata_a,

	// data port
	output logic read_b,
	output logic write_b,
	output logic [3:0] wmask_b,
	output rv32i_types::rv32i_word address_b,
	output rv32i_types::rv32i_word wdata_b,
	input logic resp_b,
	input rv32i_types::rv32i_word rdata_b
);
	import rv32i_types::*;

	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	rv32i_control_word id_ctrl;
	rv32i_control_word wb_ctrl;
	rv32i_reg wb_rd;
	logic wb_we;
	rv32i_word wb_data;
	logic br_taken;
	rv32i_word br_target;
	logic pc_load;
	logic if_id_load;
	logic id_ex_load;
	logic ex_mem_load;
	logic mem_wb_load;
	logic if_id_flush;
	logic id_ex_flush;
	fwd_sel_t fwd_sel1;
	fwd_sel_t fwd_sel2;

	assign read_a = ~rst; // fetch never idles.
	assign write_a = 1'b0;
	assign wmask_a = 4'b0000;
	assign wdata_a = '0;

	assign read_b = ex_mem.ctrl.mem_read;
	assign write_b = ex_mem.ctrl.mem_write;
	assign wmask_b = 4'b1111; // word accesses only.
	assign address_b = ex_mem.alu_out;
	assign wdata_b = ex_mem.store_data;

	pipe_control pipe_control_i (
		.clk, .rst, .read_b, .write_b, .resp_a, .resp_b,
		.id_rs1(id_ctrl.rs1), .id_rs2(id_ctrl.rs2),
		.ex_ctrl(id_ex.ctrl), .mem_ctrl(ex_mem.ctrl), .wb_ctrl, .br_taken,
		.pc_load, .if_id_load, .id_ex_load, .ex_mem_load, .mem_wb_load,
		.if_id_flush, .id_ex_flush, .fwd_sel1, .fwd_sel2
	);

	if_stage if_stage_i (
		.clk, .rst, .pc_load, .if_id_load, .if_id_flush,
		.br_taken, .br_target, .rdata_a, .address_a, .if_id
	);

	control_memory control_memory_i (
		.instr(if_id.instr),
		.ctrl(id_ctrl)
	);

	id_stage id_stage_i (
		.clk, .rst, .if_id, .ctrl(id_ctrl), .id_ex_load, .id_ex_flush,
		.wb_rd, .wb_we, .wb_data, .id_ex
	);

	ex_stage ex_stage_i (
		.clk, .rst, .id_ex, .ex_mem_load, .fwd_sel1, .fwd_sel2,
		.mem_fwd_data(ex_mem.alu_out), .wb_data, .ex_mem, .br_taken, .br_target
	);

	wb_stage wb_stage_i (
		.clk, .rst, .ex_mem, .mem_wb_load, .rdata_b,
		.wb_rd, .wb_we, .wb_data, .wb_ctrl
	);

endmodule : mp3_cpu

// ==== design/pipe_control.sv ====
`timescale 1ns/10ps

module pipe_control (
	input logic clk,
	input logic rst,
	input logic read_b,
	input logic write_b,
	input logic resp_a,
	input logic resp_b,
	input rv32i_types::rv32i_reg id_rs1,
	input rv32i_types::rv32i_reg id_rs2,
	input rv32i_types::rv32i_control_word ex_ctrl,
	input rv32i_types::rv32i_control_word mem_ctrl,
	input rv32i_types::rv32i_control_word wb_ctrl,
	input logic br_taken,
	output logic pc_load,
	output logic if_id_load,
	output logic id_ex_load,
	output logic ex_mem_load,
	output logic mem_wb_load,
	output logic if_id_flush,
	output logic id_ex_flush,
	output rv32i_types::fwd_sel_t fwd_sel1,
	output rv32i_types::fwd_sel_t fwd_sel2
);
	import rv32i_types::*;

	logic freeze;
	logic load_use;

	function automatic fwd_sel_t pick_src(rv32i_reg rs, rv32i_control_word m,
			rv32i_control_word w);
		if (rs == '0)
			return fwd_none;
		if (m.load_regfile && m.rd == rs)
			return fwd_mem;
		if (w.load_regfile && w.rd == rs)
			return fwd_wb;
		return fwd_none;
	endfunction

	// read_a is held high, so a missing resp_a is a fetch stall.
	assign freeze = ~resp_a | ((read_b | write_b) & ~resp_b);
	assign load_use = ex_ctrl.mem_read && ex_ctrl.load_regfile &&
		(ex_ctrl.rd == id_rs1 || ex_ctrl.rd == id_rs2);

	assign pc_load = ~freeze & ~load_use;
	assign if_id_load = ~freeze & ~load_use;
	assign id_ex_load = ~freeze;
	assign ex_mem_load = ~freeze;
	assign mem_wb_load = ~freeze;
	assign if_id_flush = ~freeze & br_taken; // two younger instrs die.
	assign id_ex_flush = ~freeze & (br_taken | load_use);

	always_comb begin
		fwd_sel1 = pick_src(ex_ctrl.rs1, mem_ctrl, wb_ctrl);
		fwd_sel2 = pick_src(ex_ctrl.rs2, mem_ctrl, wb_ctrl);
	end

	assert property (@(posedge clk) disable iff (rst) !(read_b && write_b));
	// a frozen branch stays pending until the pipe moves.
	assert property (@(posedge clk) disable iff (rst)
		(freeze && br_taken) |=> br_taken);

endmodule : pipe_control

// ==== design/rv32i_types.sv ====
package rv32i_types;

typedef logic [31:0] rv32i_word;
typedef logic [4:0] rv32i_reg;

typedef enum logic [6:0] {
	op_lui = 7'b0110111,
	op_jal = 7'b1101111,
	op_br = 7'b1100011,
	op_load = 7'b0000011,
	op_store = 7'b0100011,
	op_imm = 7'b0010011,
	op_reg = 7'b0110011
} rv32i_opcode;

typedef enum logic [2:0] {
	alu_add,
	alu_sub,
	alu_and,
	alu_or,
	alu_xor,
	alu_pass_b
} alu_ops;

typedef enum logic [1:0] {
	alu_out,
	mem_rdata,
	pc_plus4
} regfilemux_sel_t;

typedef enum logic [1:0] {
	fwd_none,
	fwd_mem,
	fwd_wb
} fwd_sel_t;

typedef struct packed {
	rv32i_opcode opcode;
	rv32i_reg rs1;
	rv32i_reg rs2;
	rv32i_reg rd;
	rv32i_word imm;
	alu_ops aluop;
	logic alumux2_sel; // 1 picks the immediate.
	logic is_branch;
	logic branch_ne;
	logic is_jump;
	logic mem_read;
	logic mem_write;
	logic load_regfile;
	regfilemux_sel_t regfilemux_sel;
} rv32i_control_word;

typedef struct packed {
	rv32i_word pc;
	rv32i_word instr;
} if_id_t;

typedef struct packed {
	rv32i_word pc;
	rv32i_word rs1_val;
	rv32i_word rs2_val;
	rv32i_control_word ctrl;
} id_ex_t;

typedef struct packed {
	rv32i_word pc;
	rv32i_word alu_out;
	rv32i_word store_data;
	rv32i_control_word ctrl;
} ex_mem_t;

typedef struct packed {
	rv32i_word pc;
	rv32i_word alu_out;
	rv32i_word rdata;
	rv32i_control_word ctrl;
} mem_wb_t;

localparam rv32i_word reset_pc = 32'h0000_0000;

localparam rv32i_control_word nop_ctrl = '{
	opcode: op_imm,
	rs1: 5'd0,
	rs2: 5'd0,
	rd: 5'd0,
	imm: 32'd0,
	aluop: alu_add,
	alumux2_sel: 1'b0,
	is_branch: 1'b0,
	branch_ne: 1'b0,
	is_jump: 1'b0,
	mem_read: 1'b0,
	mem_write: 1'b0,
	load_regfile: 1'b0,
	regfilemux_sel: alu_out
};

endpackage : rv32i_types

// ==== design/wb_stage.sv ====
`timescale 1ns/10ps

module wb_stage (
	input logic clk,
	input logic rst,
	input rv32i_types::ex_mem_t ex_mem,
	input logic mem_wb_load,
	input rv32i_types::rv32i_word rdata_b,
	output rv32i_types::rv32i_reg wb_rd,
	output logic wb_we,
	output rv32i_types::rv32i_word wb_data,
	output rv32i_types::rv32i_control_word wb_ctrl
);
	import rv32i_types::*;

	mem_wb_t mem_wb;

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_wb <= '{pc: '0, alu_out: '0, rdata: '0, ctrl: nop_ctrl};
		end else if (mem_wb_load) begin
			mem_wb <= '{
				pc: ex_mem.pc,
				alu_out: ex_mem.alu_out,
				rdata: rdata_b, // valid on the resp cycle.
				ctrl: ex_mem.ctrl
			};
		end
	end

	always_comb begin
		case (mem_wb.ctrl.regfilemux_sel)
			mem_rdata: wb_data = mem_wb.rdata;
			pc_plus4: wb_data = mem_wb.pc + 32'd4; // jal link.
			default: wb_data = mem_wb.alu_out;
		endcase
	end

	assign wb_ctrl = mem_wb.ctrl;
	assign wb_rd = mem_wb.ctrl.rd;
	assign wb_we = mem_wb.ctrl.load_regfile;

endmodule : wb_stage

// ==== filelist.f ====
design/rv32i_types.sv
design/control_memory.sv
design/pipe_control.sv
design/if_stage.sv
design/id_stage.sv
design/ex_stage.sv
design/wb_stage.sv
design/mp3_cpu.sv
verif/cache_model.sv
verif/mp3_cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert -f filelist.f --top-module mp3_cpu_tb -o mp3_cpu_sim
out=$(./obj_dir/mp3_cpu_sim)
echo "$out"
echo "$out" | grep -qx "all tests passed"

// ==== verif/cache_model.sv ====
`timescale 1ns/10ps

module cache_model (
	input logic clk,
	input logic rst,
	input logic rand_delay,
	input rv32i_types::rv32i_word image [256],
	input logic read_a,
	input rv32i_types::rv32i_word address_a,
	output logic resp_a,
	output rv32i_types::rv32i_word rdata_a,
	input logic read_b,
	input logic write_b,
	input logic [3:0] wmask_b,
	input rv32i_types::rv32i_word address_b,
	input rv32i_types::rv32i_word wdata_b,
	output logic resp_b,
	output rv32i_types::rv32i_word rdata_b
);
	import rv32i_types::*;

	rv32i_word mem [256];
	logic [1:0] wait_a = 2'd0; // cycles left before the next resp.
	logic [1:0] wait_b = 2'd0;
	logic [31:0] seed = 32'h99ef;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	assign resp_a = read_a && wait_a == 2'd0;
	assign rdata_a = mem[address_a[9:2]];
	assign resp_b = (read_b || write_b) && wait_b == 2'd0;
	assign rdata_b = mem[address_b[9:2]];

	always @(posedge clk) begin
		logic [31:0] s;
		rv32i_word w;
		s = seed;
		w = mem[address_b[9:2]];
		if (rst) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= image[i];
			wait_a <= 2'd0;
			wait_b <= 2'd0;
		end else begin
			if (resp_a) begin
				s = lcg_next(s);
				wait_a <= rand_delay ? s[17:16] : 2'd0; // delay of the next fetch.
			end else if (read_a) begin
				wait_a <= wait_a - 2'd1;
			end
			if (resp_b) begin
				s = lcg_next(s);
				wait_b <= rand_delay ? s[17:16] : 2'd0;
			end else if (read_b || write_b) begin
				wait_b <= wait_b - 2'd1;
			end
			if (write_b && resp_b) begin
				for (int k = 0; k < 4; k++)
					if (wmask_b[k])
						w[8*k +: 8] = wdata_b[8*k +: 8];
				mem[address_b[9:2]] <= w;
			end
		end
		seed <= s;
	end

endmodule : cache_model

// ==== verif/mp3_cpu_tb.sv ====
`timescale 1ns/10ps

module mp3_cpu_tb;
	import rv32i_types::*;

	localparam int num_tests = 8;
	localparam int store_limit = 1500; // cycles allowed for a program's stores.

	logic clk;
	logic rst;
	logic rand_delay;
	logic read_a;
	logic write_a;
	logic [3:0] wmask_a;
	rv32i_word address_a;
	rv32i_word wdata_a;
	logic resp_a;
	rv32i_word rdata_a;
	logic read_b;
	logic write_b;
	logic [3:0] wmask_b;
	rv32i_word address_b;
	rv32i_word wdata_b;
	logic resp_b;
	rv32i_word rdata_b;

	rv32i_word image [256];
	int prog_len;
	rv32i_word exp_addr [$];
	rv32i_word exp_data [$];
	rv32i_word st_addr [$];
	rv32i_word st_data [$];
	logic [3:0] st_mask [$];
	int err_count;
	int pass_count;
	int fail_count;
	logic was_rst;

	mp3_cpu mp3_cpu_i (.*);

	cache_model cache_model_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(num_tests * 2000 * 8);
		$display("watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	// a store repeats while fetch stalls, so log it once the pipe moves on.
	always @(negedge clk) begin
		if (!rst && write_b && resp_b && resp_a) begin
			st_addr.push_back(address_b);
			st_data.push_back(wdata_b);
			st_mask.push_back(wmask_b);
		end
	end

	// instruction port only reads.
	always @(negedge clk) begin
		if (!rst) begin
			check_bit("read_a", read_a, 1'b1);
			check_bit("write_a", write_a, 1'b0);
			check_mask("wmask_a", wmask_a, 4'b0000);
			check_word("wdata_a", wdata_a, 32'd0);
		end
		if (!rst && was_rst) begin // first cycle out of reset.
			check_word("address_a", address_a, reset_pc);
			check_bit("read_b", read_b, 1'b0);
			check_bit("write_b", write_b, 1'b0);
		end
		was_rst = rst;
	end

	function automatic rv32i_word addi(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic rv32i_word lw(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic rv32i_word sw(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv32i_word lui(int rd, int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic rv32i_word jal(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic rv32i_word branch(int f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			7'b1100011};
	endfunction

	function automatic rv32i_word rtype(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	task automatic put_instr(rv32i_word w);
		image[prog_len] = w;
		prog_len++;
	endtask

	task automatic expect_store(int addr, rv32i_word data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic check_word(string name, rv32i_word got, rv32i_word exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_mask(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic arith_program();
		rv32i_word a;
		rv32i_word b;
		rv32i_word u;
		a = 32'd100;
		b = -32'sd7;
		u = 32'h12345 << 12;
		put_instr(addi(1, 0, 100));
		put_instr(addi(2, 0, -7));
		put_instr(lui(3, 'h12345));
		put_instr(rtype(0, 0, 4, 1, 2)); // add.
		put_instr(rtype(32, 0, 5, 1, 2)); // sub.
		put_instr(rtype(0, 7, 6, 1, 2)); // and.
		put_instr(rtype(0, 6, 7, 3, 1));
		put_instr(rtype(0, 4, 8, 3, 2)); // xor.
		for (int r = 1; r <= 8; r++)
			put_instr(sw(r, 0, 'h1fc + 4 * r));
		put_instr(addi(0, 1, 55));
		put_instr(sw(0, 0, 'h220));
		put_instr(jal(0, 0));
		expect_store('h200, a);
		expect_store('h204, b);
		expect_store('h208, u);
		expect_store('h20c, a + b);
		expect_store('h210, a - b);
		expect_store('h214, a & b);
		expect_store('h218, u | a);
		expect_store('h21c, u ^ b);
		expect_store('h220, 32'd0);
	endtask

	task automatic forwarding_program();
		rv32i_word r1;
		rv32i_word r2;
		rv32i_word r3;
		rv32i_word r4;
		rv32i_word r6;
		r1 = 32'd5;
		r2 = r1 + 32'd3;
		r3 = r2 + r1;
		r4 = r3 - r1;
		r6 = 32'd11 ^ r4;
		put_instr(addi(1, 0, 5));
		put_instr(addi(2, 1, 3)); // distance 1.
		put_instr(rtype(0, 0, 3, 2, 1)); // x1 at distance 2.
		put_instr(rtype(32, 0, 4, 3, 1)); // x1 at distance 3.
		put_instr(addi(5, 0, 11));
		put_instr(addi(10, 0, 1));
		put_instr(addi(11, 0, 2));
		put_instr(rtype(0, 4, 6, 5, 4));
		put_instr(sw(6, 0, 'h240)); // store data from MEM.
		put_instr(sw(2, 0, 'h244));
		put_instr(sw(3, 0, 'h248));
		put_instr(sw(4, 0, 'h24c));
		put_instr(jal(0, 0));
		expect_store('h240, r6);
		expect_store('h244, r2);
		expect_store('h248, r3);
		expect_store('h24c, r4);
	endtask

	task automatic load_use_program();
		image['h180 >> 2] = 32'h0000_1234;
		image['h184 >> 2] = 32'hcafe_f00d;
		put_instr(lw(1, 0, 'h180));
		put_instr(addi(2, 1, 'h10));
		put_instr(sw(2, 0, 'h260));
		put_instr(lw(3, 0, 'h184));
		put_instr(sw(3, 0, 'h264)); // store data right behind the load.
		put_instr(jal(0, 0));
		expect_store('h260, 32'h0000_1234 + 32'h10);
		expect_store('h264, 32'hcafe_f00d);
	endtask

	task automatic branch_program();
		rv32i_word link;
		put_instr(addi(1, 0, 7));
		put_instr(addi(2, 0, 7));
		put_instr(addi(31, 0, 'h7ad)); // marker.
		put_instr(branch(0, 1, 2, 12)); // beq taken.
		put_instr(sw(31, 0, 'h2f0));
		put_instr(sw(31, 0, 'h2f4));
		put_instr(branch(1, 1, 2, 12)); // bne not taken.
		put_instr(sw(1, 0, 'h280));
		link = prog_len * 4 + 4;
		put_instr(jal(5, 12));
		put_instr(sw(31, 0, 'h2f8));
		put_instr(sw(31, 0, 'h2fc));
		put_instr(sw(5, 0, 'h284));
		put_instr(jal(0, 0));
		expect_store('h280, 32'd7);
		expect_store('h284, link);
	endtask

	task automatic build_program(int prog);
		for (int i = 0; i < 256; i++)
			image[i] = '0;
		prog_len = 0;
		exp_addr.delete();
		exp_data.delete();
		case (prog)
			0: arith_program();
			1: forwarding_program();
			2: load_use_program();
			default: branch_program();
		endcase
	endtask

	task automatic run_test(string name, int prog, logic delays);
		int errs_before;
		int base;
		int cycles;
		int seen;
		errs_before = err_count;
		build_program(prog);
		@(posedge clk);
		rst <= 1'b1;
		rand_delay <= delays;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		base = st_addr.size();
		cycles = 0;
		while (st_addr.size() - base < exp_addr.size() && cycles < store_limit) begin
			@(posedge clk);
			cycles++;
		end
		repeat (20) @(posedge clk); // stray stores would show up here.
		seen = st_addr.size() - base;
		if (seen < exp_addr.size()) begin
			$display("%s: timed out with %0d of %0d stores seen", name, seen, exp_addr.size());
			err_count++;
		end else if (seen > exp_addr.size()) begin
			$display("%s: %0d stores seen where %0d were expected", name, seen,
				exp_addr.size());
			err_count++;
		end
		for (int i = 0; i < exp_addr.size(); i++) begin
			if (base + i < st_addr.size()) begin
				check_word($sformatf("address_b[%0d]", i), st_addr[base + i], exp_addr[i]);
				check_word($sformatf("wdata_b[%0d]", i), st_data[base + i], exp_data[i]);
				check_mask($sformatf("wmask_b[%0d]", i), st_mask[base + i], 4'b1111);
			end
		end
		if (err_count == errs_before) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: FAIL", name);
		end
	endtask

	initial begin
		rst = 1'b1;
		rand_delay = 1'b0;
		was_rst = 1'b1;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		run_test("arithmetic", 0, 1'b0);
		run_test("forwarding", 1, 1'b0);
		run_test("load-use", 2, 1'b0);
		run_test("control flow", 3, 1'b0);
		run_test("backpressure arithmetic", 0, 1'b1);
		run_test("backpressure forwarding", 1, 1'b1);
		run_test("backpressure load-use", 2, 1'b1);
		run_test("backpressure control flow", 3, 1'b1);
		$display("summary: %0d ok, %0d bad, %0d wrong checks", pass_count, fail_count,
			err_count);
		if (fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule : mp3_cpu_tb
